// ==== Makefile ====
# Verilator build and run of the chip link testbench

TOP = tb_chip_link

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

// ==== chip_link_consts.svh ====
`ifndef CHIP_LINK_CONSTS_SVH
`define CHIP_LINK_CONSTS_SVH

// register field widths
`define CL_DATA_W        16
`define CL_ADDR_W        7

// serial frame, data word above the address
`define CL_FRAME_LEN     23
// reply bits sampled after capture
`define CL_REPLY_LEN     16

// command fifo entries, also the host's starting credits
`define CL_CMD_DEPTH     4
// reply buffer entries
`define CL_REPLY_DEPTH   4
// host credits held by the reply side after reset
`define CL_REPLY_CREDITS 2

`endif

// ==== chip_link_pkg.sv ====
`include "chip_link_consts.svh"

package chip_link_pkg;

    ////////////////////
    // vector types

    typedef logic [`CL_DATA_W-1:0]    reg_data_t;
    typedef logic [`CL_ADDR_W-1:0]    reg_addr_t;
    typedef logic [`CL_FRAME_LEN-1:0] frame_t;

    ////////////////////
    // host words

    // one register access, 24 bits
    typedef struct packed {
        logic      is_read;
        reg_addr_t addr;
        reg_data_t data;
    } cmd_t;

    // read result back to host, 23 bits
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } reply_t;

    // frame engine states
    typedef enum logic [2:0] {
        st_idle,
        st_shift,
        st_capture,
        st_sample,
        st_hand_off
    } engine_state_t;

endpackage

// ==== chip_link_sva.sv ====
`include "chip_link_consts.svh"

module chip_link_sva (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 update,
    input logic                                 capture,
    input logic                                 cmd_valid,
    input logic [$clog2(`CL_CMD_DEPTH + 1)-1:0] cmd_count,
    input logic                                 reply_valid,
    input logic                                 reply_credit
);

    timeunit 1ns;
    timeprecision 1ps;

    // assertion failures so far
    int unsigned fail_count = 0;
    // reply credits left to the sender as seen on the host pins
    int          host_credits;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            host_credits <= `CL_REPLY_CREDITS;
        end else begin
            host_credits <= host_credits + int'(reply_credit) - int'(reply_valid);
        end
    end

    // strobes belong to different frame types
    a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
        !(update && capture))
        else begin
            fail_count++;
            $error("update and capture high in the same cycle");
        end

    a_capture_pulse: assert property (@(posedge clk) disable iff (reset)
        capture |=> !capture)
        else begin
            fail_count++;
            $error("capture held for more than one cycle");
        end

    // host must own a credit for every word
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        cmd_valid |-> (cmd_count != ($clog2(`CL_CMD_DEPTH + 1))'(`CL_CMD_DEPTH)))
        else begin
            fail_count++;
            $error("command pushed into a full queue");
        end

    a_reply_credit: assert property (@(posedge clk) disable iff (reset)
        reply_valid |-> (host_credits > 0))
        else begin
            fail_count++;
            $error("reply sent with no credit left");
        end

endmodule

bind chip_link_top chip_link_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .update       (update),
    .capture      (capture),
    .cmd_valid    (cmd_valid),
    .cmd_count    (u_cmd_queue.count),
    .reply_valid  (reply_valid),
    .reply_credit (reply_credit)
);

// ==== chip_link_top.sv ====
module chip_link_top
    import chip_link_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    // host command channel
    input  cmd_t   cmd,
    input  logic   cmd_valid,
    output logic   cmd_credit,
    // host reply channel
    output reply_t reply,
    output logic   reply_valid,
    input  logic   reply_credit,
    // chip pins
    output logic   spi_din,
    output logic   update,
    output logic   capture,
    input  logic   spi_out
);

    ////////////////////
    // internal links

    // queue to engine
    cmd_t   q_cmd;
    logic   q_valid;
    logic   q_pop;

    // engine to sender
    reply_t eng_reply;
    logic   eng_reply_valid;
    logic   sender_ready;

    cmd_queue u_cmd_queue (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_credit (cmd_credit),
        .q_cmd      (q_cmd),
        .q_valid    (q_valid),
        .q_pop      (q_pop)
    );

    spi_frame_engine u_frame_engine (
        .clk             (clk),
        .reset           (reset),
        .q_cmd           (q_cmd),
        .q_valid         (q_valid),
        .q_pop           (q_pop),
        .spi_din         (spi_din),
        .update          (update),
        .capture         (capture),
        .spi_out         (spi_out),
        .eng_reply       (eng_reply),
        .eng_reply_valid (eng_reply_valid),
        .sender_ready    (sender_ready)
    );

    reply_sender u_reply_sender (
        .clk             (clk),
        .reset           (reset),
        .eng_reply       (eng_reply),
        .eng_reply_valid (eng_reply_valid),
        .sender_ready    (sender_ready),
        .reply           (reply),
        .reply_valid     (reply_valid),
        .reply_credit    (reply_credit)
    );

endmodule

// ==== cmd_queue.sv ====
`include "chip_link_consts.svh"

module cmd_queue
    import chip_link_pkg::*;
(
    input  logic clk,
    input  logic reset,
    // host side
    input  cmd_t cmd,
    input  logic cmd_valid,
    output logic cmd_credit,
    // engine side
    output cmd_t q_cmd,
    output logic q_valid,
    input  logic q_pop
);

    // depth is a power of two, pointers wrap on their own
    localparam int ptr_w = $clog2(`CL_CMD_DEPTH);
    localparam int cnt_w = $clog2(`CL_CMD_DEPTH + 1);

    cmd_t mem [`CL_CMD_DEPTH];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full    = (count == cnt_w'(`CL_CMD_DEPTH));
    // host spends a credit per word, so full never sees a push
    assign push    = cmd_valid && !full;
    assign pop     = q_pop && q_valid;
    assign q_valid = (count != '0);
    // head entry, read straight out of the array
    assign q_cmd   = mem[rd_ptr];

    ////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd;
        end
    end

    ////////////////////
    // pointers, fill level and credit return

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per entry taken by the engine
            cmd_credit <= pop;
        end
    end

endmodule

// ==== project.f ====
+incdir+.
chip_link_pkg.sv
cmd_queue.sv
spi_frame_engine.sv
reply_sender.sv
chip_link_top.sv
chip_link_sva.sv
tb_chip_link.sv

// ==== reply_sender.sv ====
`include "chip_link_consts.svh"

module reply_sender
    import chip_link_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    // frame engine
    input  reply_t eng_reply,
    input  logic   eng_reply_valid,
    output logic   sender_ready,
    // host side
    output reply_t reply,
    output logic   reply_valid,
    input  logic   reply_credit
);

    // power of two depth, pointers wrap naturally
    localparam int ptr_w = $clog2(`CL_REPLY_DEPTH);
    localparam int cnt_w = $clog2(`CL_REPLY_DEPTH + 1);
    localparam int credit_w = $clog2(`CL_REPLY_CREDITS + 1);

    reply_t mem [`CL_REPLY_DEPTH];

    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [cnt_w-1:0]    count;
    logic [credit_w-1:0] credits;
    logic                push;
    logic                send;

    assign sender_ready = (count != cnt_w'(`CL_REPLY_DEPTH));
    assign push         = eng_reply_valid && sender_ready;
    // head word goes out whenever a credit is in hand
    assign send         = (count != '0) && (credits != '0);
    assign reply_valid  = send;
    assign reply        = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= eng_reply;
        end
    end

    ////////////////////
    // fifo control and host credits

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= credit_w'(`CL_REPLY_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // returned credit and spent credit cancel out
            case ({reply_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== spi_frame_engine.sv ====
`include "chip_link_consts.svh"

module spi_frame_engine
    import chip_link_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    // command queue
    input  cmd_t   q_cmd,
    input  logic   q_valid,
    output logic   q_pop,
    // chip pins
    output logic   spi_din,
    output logic   update,
    output logic   capture,
    input  logic   spi_out,
    // reply sender
    output reply_t eng_reply,
    output logic   eng_reply_valid,
    input  logic   sender_ready
);

    // one counter covers both the frame and the reply bits
    localparam int cnt_w = $clog2(`CL_FRAME_LEN);
    localparam int last_bit = `CL_FRAME_LEN - 1;
    localparam int last_sample = `CL_REPLY_LEN - 1;

    engine_state_t    state;
    logic [cnt_w-1:0] bit_cnt;
    logic             is_read;
    frame_t           shift_reg;
    reg_addr_t        cur_addr;
    reg_data_t        rx_data;
    reg_data_t        load_data;
    logic             frame_end;

    // take a command only when nothing is in flight
    assign q_pop = (state == st_idle) && q_valid;

    // reads send the address with an all-zero data field
    assign load_data = q_cmd.is_read ? '0 : q_cmd.data;

    assign frame_end = (state == st_shift) && (bit_cnt == cnt_w'(last_bit));

    ////////////////////
    // pin drive

    // lsb of the shift register is the current bit
    assign spi_din = (state == st_shift) && shift_reg[0];
    // strobe only on bit 22 of a write
    assign update  = frame_end && !is_read;
    assign capture = (state == st_capture);

    // reply held until the sender has room
    assign eng_reply       = '{addr: cur_addr, data: rx_data};
    assign eng_reply_valid = (state == st_hand_off);

    ////////////////////
    // control fsm

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= st_idle;
            bit_cnt <= '0;
            is_read <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (q_pop) begin
                        state   <= st_shift;
                        bit_cnt <= '0;
                        is_read <= q_cmd.is_read;
                    end
                end
                st_shift: begin
                    if (frame_end) begin
                        // writes are done, reads go on to capture
                        state   <= is_read ? st_capture : st_idle;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_capture: begin
                    state <= st_sample;
                end
                st_sample: begin
                    if (bit_cnt == cnt_w'(last_sample)) begin
                        state <= st_hand_off;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_hand_off: begin
                    // full reply buffer parks us here
                    if (sender_ready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////
    // datapath

    always_ff @(posedge clk) begin
        if (q_pop) begin
            shift_reg <= {load_data, q_cmd.addr};
            cur_addr  <= q_cmd.addr;
        end else if (state == st_shift) begin
            shift_reg <= shift_reg >> 1;
        end
        // chip answers lsb first, so shift in from the top
        if (state == st_sample) begin
            rx_data <= {spi_out, rx_data[`CL_DATA_W-1:1]};
        end
    end

endmodule

// ==== tb_chip_link.sv ====
`include "chip_link_consts.svh"

module tb_chip_link
    import chip_link_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 40;
    // watchdog budget is commands times worst case cycles each
    localparam int n_cmds = 30;
    localparam int cycles_per_cmd = 60;
    localparam int n_rand_writes = 20;
    localparam int n_held_reads = 6;
    localparam int n_cred_en = 2048;
    localparam int n_regs = 2**`CL_ADDR_W;

    logic   clk;
    logic   reset;
    cmd_t   cmd;
    logic   cmd_valid;
    logic   cmd_credit;
    reply_t reply;
    logic   reply_valid;
    logic   reply_credit;
    logic   spi_din;
    logic   update;
    logic   capture;
    logic   spi_out;

    // host side bookkeeping
    integer    seed;
    int        errors = 0;
    int        cmds_sent;
    int        credits_back;
    int        replies_rcvd;
    int        credits_returned;
    int        writes_sent;
    int        upd_count;
    logic      hold_credits;
    logic      cred_en [n_cred_en];
    reg_addr_t wr_addr [n_rand_writes];
    reg_data_t wr_data [n_rand_writes];
    reg_data_t shadow [n_regs];
    reply_t    exp_q [$];
    cmd_t      wr_q [$];

    chip_link_top dut (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_credit   (cmd_credit),
        .reply        (reply),
        .reply_valid  (reply_valid),
        .reply_credit (reply_credit),
        .spi_din      (spi_din),
        .update       (update),
        .capture      (capture),
        .spi_out      (spi_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2);
            clk = ~clk;
        end
    end

    initial begin
        #(n_cmds * cycles_per_cmd * clk_period);
        $display("watchdog expired, run not done after %0d cycles", n_cmds * cycles_per_cmd);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////
    // helpers

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // expected read data from the host's record of its writes
    function automatic reg_data_t ref_read(input reg_addr_t addr);
        return shadow[addr];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic send_cmd(input cmd_t c);
        // stall while all command credits are spent
        while (cmds_sent - credits_back >= `CL_CMD_DEPTH) begin
            cmd_valid = 1'b0;
            next_cycle();
        end
        cmd       = c;
        cmd_valid = 1'b1;
        cmds_sent++;
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic issue_write(input reg_addr_t addr, input reg_data_t data);
        cmd_t c;
        c = {1'b0, addr, data};
        shadow[addr] = data;
        wr_q.push_back(c);
        writes_sent++;
        send_cmd(c);
    endtask

    task automatic issue_read(input reg_addr_t addr);
        reply_t r;
        r = {addr, ref_read(addr)};
        exp_q.push_back(r);
        send_cmd({1'b1, addr, reg_data_t'(0)});
    endtask

    // idle once no write or read is outstanding and all reply credits are back
    task automatic wait_idle();
        while (exp_q.size() != 0 || wr_q.size() != 0
               || replies_rcvd != credits_returned) begin
            next_cycle();
        end
    endtask

    ////////////////////
    // chip model

    initial begin
        reg_data_t mem [n_regs];
        frame_t    sr;
        reg_data_t rd_word;
        int        rd_left;
        cmd_t      w;
        spi_out   = 1'b0;
        sr        = '0;
        rd_word   = '0;
        rd_left   = 0;
        upd_count = 0;
        for (int i = 0; i < n_regs; i++) begin
            mem[i] = '0;
        end
        forever begin
            @(posedge clk);
            #2;
            // reply goes out lsb first with one bit per edge after capture
            if (rd_left > 0) begin
                spi_out = rd_word[0];
                rd_word = rd_word >> 1;
                rd_left--;
            end else begin
                spi_out = 1'b0;
            end
            @(negedge clk);
            // sliding window holds the last 23 bits
            // the read frame ended one cycle before capture
            if (capture) begin
                rd_word = mem[sr[`CL_ADDR_W-1:0]];
                rd_left = `CL_REPLY_LEN;
            end
            sr = {spi_din, sr[`CL_FRAME_LEN-1:1]};
            if (update) begin
                upd_count++;
                mem[sr[`CL_ADDR_W-1:0]] = sr[`CL_FRAME_LEN-1:`CL_ADDR_W];
                if (wr_q.size() == 0) begin
                    $display("update pulse at %0t ns with no write outstanding", $time);
                    errors++;
                end else begin
                    w = wr_q.pop_front();
                    check("frame addr", 32'(sr[`CL_ADDR_W-1:0]), 32'(w.addr));
                    check("frame data", 32'(sr[`CL_FRAME_LEN-1:`CL_ADDR_W]), 32'(w.data));
                end
            end
        end
    end

    ////////////////////
    // host monitor and reply compare

    initial begin
        reply_t r;
        credits_back = 0;
        replies_rcvd = 0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (cmd_credit) begin
                    credits_back++;
                end
                if (reply_valid) begin
                    replies_rcvd++;
                    if (exp_q.size() == 0) begin
                        $display("reply at %0t ns with no read outstanding", $time);
                        errors++;
                    end else begin
                        r = exp_q.pop_front();
                        check("reply.addr", 32'(reply.addr), 32'(r.addr));
                        check("reply.data", 32'(reply.data), 32'(r.data));
                    end
                end
            end
        end
    end

    // reply credits go back under a random enable
    initial begin
        int cyc;
        cyc              = 0;
        reply_credit     = 1'b0;
        credits_returned = 0;
        forever begin
            next_cycle();
            cyc++;
            if (!reset && !hold_credits && replies_rcvd > credits_returned
                && cred_en[cyc % n_cred_en]) begin
                reply_credit = 1'b1;
                credits_returned++;
            end else begin
                reply_credit = 1'b0;
            end
        end
    end

    ////////////////////
    // main sequence

    initial begin
        int base;
        seed         = 32'h1e76;
        reset        = 1'b1;
        cmd          = '0;
        cmd_valid    = 1'b0;
        hold_credits = 1'b0;
        cmds_sent    = 0;
        writes_sent  = 0;
        for (int i = 0; i < n_regs; i++) begin
            shadow[i] = '0;
        end
        // random writes stay in the low half so the upper half reads as zero
        for (int i = 0; i < n_rand_writes; i++) begin
            wr_addr[i] = reg_addr_t'($random(seed)) & 7'h3f;
            wr_data[i] = reg_data_t'($random(seed));
        end
        for (int i = 0; i < n_cred_en; i++) begin
            cred_en[i] = ($random(seed) & 1) != 0;
        end
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();

        // back to back burst uses every command credit
        issue_write(7'h15, 16'hc3a5);
        issue_read(7'h15);
        issue_write(7'h2a, 16'h5a0f);
        issue_read(7'h40);
        wait_idle();
        check("cmd_credit pulses", credits_back, `CL_CMD_DEPTH);
        check("host cmd credits", `CL_CMD_DEPTH - (cmds_sent - credits_back), `CL_CMD_DEPTH);

        for (int i = 0; i < n_rand_writes; i++) begin
            issue_write(wr_addr[i], wr_data[i]);
        end
        wait_idle();
        check("update pulses", upd_count, writes_sent);

        // host keeps its reply credits to build back-pressure
        base         = replies_rcvd;
        hold_credits = 1'b1;
        issue_read(wr_addr[0]);
        issue_read(wr_addr[7]);
        issue_read(7'h41);
        issue_read(wr_addr[13]);
        issue_read(wr_addr[19]);
        issue_read(7'h7f);
        while (cmds_sent != credits_back) begin
            next_cycle();
        end
        // window covers the last read frame with its reply and hand-off
        repeat (`CL_FRAME_LEN + `CL_REPLY_LEN + 4) @(posedge clk);
        #2;
        check("replies while held", replies_rcvd - base, `CL_REPLY_CREDITS);
        hold_credits = 1'b0;
        wait_idle();
        check("replies after release", replies_rcvd - base, n_held_reads);

        $display("run finished: %0d check errors, %0d assertion failures, %0d replies",
                 errors, dut.u_sva.fail_count, replies_rcvd);
        if (errors == 0 && dut.u_sva.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
